//--- tb.f
logic/mmu_pkg.sv
logic/tlb_array.sv
logic/tlb_match.sv
logic/addr_xlate.sv
logic/tlb_maint.sv
logic/mmu_top.sv
+incdir+dv
dv/mmu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mmu_tb -f tb.f -o mmu_sim > build.log 2>&1 \
    && ./obj_dir/mmu_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log && { echo "test failed, see sim.log"; exit 1; }
echo "test passed"
exit 0

//--- dv/mmu_model.svh
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

typedef enum logic [3:0] {
    op_wi,
    op_wr,
    op_fetch,
    op_load,
    op_store,
    op_probe,
    op_read,
    op_idle
} op_t;

// one table step, hi also carries the ASID used by lookups
typedef struct packed {
    op_t         op;
    logic [31:0] hi;
    logic [31:0] mask;
    logic [31:0] lo0;
    logic [31:0] lo1;
    logic [31:0] index;
    logic [31:0] vaddr;
} step_t;

// kseg0 and kseg1 cover 0x8000_0000..0xBFFF_FFFF
function automatic bit seg_unmapped(input logic [31:0] va);
    return va >= 32'h8000_0000 && va <= 32'hBFFF_FFFF;
endfunction

function automatic logic [frame_w-1:0] unmapped_frame(input logic [31:0] va);
    return va[31:12] & 20'h1_FFFF;
endfunction

// kseg1 always, monitor window only for data
function automatic bit unmapped_uncached(input logic [31:0] va, input bit data_side);
    bit window;
    window = data_side && va >= 32'h8010_0000 && va <= 32'h803F_FFFF;
    return (va >= 32'hA000_0000 && va <= 32'hBFFF_FFFF) || window;
endfunction

function automatic bit entry_hit(input logic [31:0] va, input logic [7:0] asid,
                                 input logic [31:0] hi, input logic [31:0] mask,
                                 input bit g);
    return (((va ^ hi) & ~mask & 32'hFFFF_E000) == 32'h0) && (g || hi[7:0] == asid);
endfunction

// even page below bit 12, odd page above
function automatic logic [31:0] page_lo(input logic [31:0] va, input logic [31:0] lo0,
                                        input logic [31:0] lo1);
    return va[offset_w] ? lo1 : lo0;
endfunction

// G is not held per EntryLo
function automatic logic [31:0] stored_lo(input logic [31:0] lo);
    return lo & 32'h03FF_FFFE;
endfunction

`endif

//--- dv/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;
    import mmu_pkg::*;
    `include "mmu_model.svh"

    localparam int n_entries = entries_default;
    localparam int index_w   = $clog2(n_entries);
    localparam int period    = 4;

    logic clk = 1'b0;
    logic rst;
    logic [31:0] inst_vaddr;
    logic [31:0] data_vaddr;
    logic inst_en;
    logic mem_read;
    logic mem_write;
    logic [frame_w-1:0] inst_pfn;
    logic [frame_w-1:0] data_pfn;
    logic no_cache_i;
    logic no_cache_d;
    logic inst_tlb_refill;
    logic inst_tlb_invalid;
    logic data_tlb_refill;
    logic data_tlb_invalid;
    logic data_tlb_modify;
    logic tlbp;
    logic tlbr;
    logic tlbwi;
    logic tlbwr;
    logic [31:0] entryhi_in;
    logic [31:0] pagemask_in;
    logic [31:0] entrylo0_in;
    logic [31:0] entrylo1_in;
    logic [31:0] index_in;
    logic [31:0] random_in;
    logic [31:0] entryhi_out;
    logic [31:0] pagemask_out;
    logic [31:0] entrylo0_out;
    logic [31:0] entrylo1_out;
    logic [31:0] index_out;

    // reference TLB contents
    logic [31:0] ref_hi   [n_entries];
    logic [31:0] ref_mask [n_entries];
    logic [31:0] ref_lo0  [n_entries];
    logic [31:0] ref_lo1  [n_entries];
    bit          ref_g    [n_entries];

    step_t steps[$];
    bit table_ready = 1'b0;
    logic [31:0] lfsr_state = 32'h7208_ef7c;
    int checks = 0;
    int errors = 0;

    mmu_top #(
        .n_entries (n_entries),
        .index_w   (index_w)
    ) dut (
        .clk (clk), .rst (rst),
        .inst_vaddr (inst_vaddr), .data_vaddr (data_vaddr),
        .inst_en (inst_en), .mem_read (mem_read), .mem_write (mem_write),
        .inst_pfn (inst_pfn), .data_pfn (data_pfn),
        .no_cache_i (no_cache_i), .no_cache_d (no_cache_d),
        .inst_tlb_refill (inst_tlb_refill), .inst_tlb_invalid (inst_tlb_invalid),
        .data_tlb_refill (data_tlb_refill), .data_tlb_invalid (data_tlb_invalid),
        .data_tlb_modify (data_tlb_modify),
        .tlbp (tlbp), .tlbr (tlbr), .tlbwi (tlbwi), .tlbwr (tlbwr),
        .entryhi_in (entryhi_in), .pagemask_in (pagemask_in),
        .entrylo0_in (entrylo0_in), .entrylo1_in (entrylo1_in),
        .index_in (index_in), .random_in (random_in),
        .entryhi_out (entryhi_out), .pagemask_out (pagemask_out),
        .entrylo0_out (entrylo0_out), .entrylo1_out (entrylo1_out),
        .index_out (index_out)
    );

    always #(period / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_frame(input string name, input logic [frame_w-1:0] got,
                               input logic [frame_w-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_step(input op_t op, input logic [31:0] hi, input logic [31:0] mask,
                            input logic [31:0] lo0, input logic [31:0] lo1,
                            input logic [31:0] index, input logic [31:0] vaddr);
        step_t s;
        s = {op, hi, mask, lo0, lo1, index, vaddr};
        steps.push_back(s);
    endtask

    // several hits merge their indices
    task automatic ref_lookup(input logic [31:0] va, input logic [7:0] asid,
                              output bit hit, output logic [index_w-1:0] idx);
        hit = 1'b0;
        idx = '0;
        for (int e = 0; e < n_entries; e++)
        begin
            if (entry_hit(va, asid, ref_hi[e], ref_mask[e], ref_g[e]))
            begin
                hit = 1'b1;
                idx = idx | index_w'(e);
            end
        end
    endtask

    // read-back EntryHi carries the combined global bit at g_pos
    function automatic logic [31:0] stored_hi(input logic [index_w-1:0] i);
        return (ref_hi[i] & 32'hFFFF_E0FF) | ({31'b0, ref_g[i]} << g_pos);
    endfunction

    task automatic check_side(input bit data_side, input logic [31:0] va,
                              input logic [7:0] asid, input bit acc, input bit st);
        bit hit;
        bit um;
        logic [index_w-1:0] idx;
        logic [31:0] lo;
        logic [frame_w-1:0] exp_frame;
        bit exp_unc;
        ref_lookup(va, asid, hit, idx);
        lo = page_lo(va, ref_lo0[idx], ref_lo1[idx]);
        um = seg_unmapped(va);
        exp_frame = um ? unmapped_frame(va) : lo[pfn_hi:pfn_lo];
        exp_unc = um ? unmapped_uncached(va, data_side) : lo[c_hi:c_lo] == uncached_attr;
        if (data_side)
        begin
            if (um || hit)
            begin
                check_frame("data_pfn", data_pfn, exp_frame);
                check_flag("no_cache_d", no_cache_d, exp_unc);
            end
            check_flag("data_tlb_refill", data_tlb_refill, !um && acc && !hit);
            check_flag("data_tlb_invalid", data_tlb_invalid, !um && acc && hit && !lo[v_pos]);
            check_flag("data_tlb_modify", data_tlb_modify,
                       !um && st && hit && lo[v_pos] && !lo[d_pos]);
        end
        else
        begin
            if (um || hit)
            begin
                check_frame("inst_pfn", inst_pfn, exp_frame);
                check_flag("no_cache_i", no_cache_i, exp_unc);
            end
            check_flag("inst_tlb_refill", inst_tlb_refill, !um && acc && !hit);
            check_flag("inst_tlb_invalid", inst_tlb_invalid, !um && acc && hit && !lo[v_pos]);
        end
    endtask

    task automatic apply_step(input int n, input step_t s);
        logic [31:0] rnd;
        logic [31:0] va;
        logic [index_w-1:0] idx;
        bit hit;
        int err_before;
        err_before = errors;
        // random offset and even/odd page for every access
        draw_bits(13, rnd);
        va = {s.vaddr[31:13], rnd[12:0]};
        @(negedge clk);
        {inst_en, mem_read, mem_write, tlbp, tlbr, tlbwi, tlbwr} = '0;
        entryhi_in = s.hi;
        inst_vaddr = va;
        data_vaddr = va;
        case (s.op)
            op_wi, op_wr:
            begin
                pagemask_in = s.mask;
                entrylo0_in = s.lo0;
                entrylo1_in = s.lo1;
                // the unused one of Index and Random points elsewhere
                index_in = (s.op == op_wi) ? s.index : ~s.index;
                random_in = (s.op == op_wr) ? s.index : ~s.index;
                tlbwi = s.op == op_wi;
                tlbwr = s.op == op_wr;
                idx = s.index[index_w-1:0];
                ref_hi[idx] = s.hi;
                ref_mask[idx] = s.mask;
                ref_lo0[idx] = stored_lo(s.lo0);
                ref_lo1[idx] = stored_lo(s.lo1);
                ref_g[idx] = s.lo0[g0_pos] & s.lo1[g0_pos];
                @(negedge clk);
                tlbwi = 1'b0;
                tlbwr = 1'b0;
            end
            op_fetch:
            begin
                inst_en = 1'b1;
                #1.5;
                check_side(1'b0, va, s.hi[7:0], 1'b1, 1'b0);
            end
            op_load, op_store:
            begin
                mem_read = s.op == op_load;
                mem_write = s.op == op_store;
                #1.5;
                check_side(1'b1, va, s.hi[7:0], 1'b1, s.op == op_store);
            end
            op_idle:
            begin
                #1.5;
                check_side(1'b0, va, s.hi[7:0], 1'b0, 1'b0);
                check_side(1'b1, va, s.hi[7:0], 1'b0, 1'b0);
            end
            op_probe:
            begin
                tlbp = 1'b1;
                #1.5;
                ref_lookup(s.hi, s.hi[7:0], hit, idx);
                check_word("index_out", index_out, hit ? 32'(idx) : probe_miss);
                if (hit)
                    check_word("entryhi_out", entryhi_out, stored_hi(idx));
            end
            default:
            begin
                tlbr = 1'b1;
                index_in = s.index;
                idx = s.index[index_w-1:0];
                #1.5;
                check_word("entryhi_out", entryhi_out, stored_hi(idx));
                check_word("pagemask_out", pagemask_out, ref_mask[idx]);
                check_word("entrylo0_out", entrylo0_out, {ref_lo0[idx][31:1], ref_g[idx]});
                check_word("entrylo1_out", entrylo1_out, {ref_lo1[idx][31:1], ref_g[idx]});
            end
        endcase
        $display("step %0d %s %s", n, s.op.name(), (errors == err_before) ? "ok" : "FAILED");
    endtask

    task automatic build_table();
        add_step(op_fetch, 32'h05, 0, 0, 0, 0, 32'h8020_1000);
        add_step(op_fetch, 32'h05, 0, 0, 0, 0, 32'hA000_2000);
        add_step(op_load,  32'h05, 0, 0, 0, 0, 32'h8010_0000);
        add_step(op_load,  32'h05, 0, 0, 0, 0, 32'h803F_F000);
        add_step(op_load,  32'h05, 0, 0, 0, 0, 32'h8040_0000);
        add_step(op_store, 32'h05, 0, 0, 0, 0, 32'hBFC0_0000);
        add_step(op_load,  32'h05, 0, 0, 0, 0, 32'h9000_0000);
        // even page cached and dirty, odd page uncached and clean
        // G only in lo0 so the pair stays private to its ASID
        add_step(op_wi, 32'h0040_0005, 0, 32'h0048_D15F, 32'h002A_F352, 1, 0);
        add_step(op_fetch, 32'h05, 0, 0, 0, 0, 32'h0040_0000);
        add_step(op_load,  32'h05, 0, 0, 0, 0, 32'h0040_0000);
        add_step(op_store, 32'h05, 0, 0, 0, 0, 32'h0040_0000);
        add_step(op_store, 32'h05, 0, 0, 0, 0, 32'h0040_0000);
        add_step(op_fetch, 32'h06, 0, 0, 0, 0, 32'h0040_0000);
        // global pair with a clean odd page
        add_step(op_wi, 32'h0060_0007, 0, 32'h0000_445F, 32'h0000_889B, 2, 0);
        add_step(op_load,  32'h33, 0, 0, 0, 0, 32'h0060_0000);
        add_step(op_store, 32'h33, 0, 0, 0, 0, 32'h0060_0000);
        add_step(op_fetch, 32'h99, 0, 0, 0, 0, 32'h0060_0000);
        // both pages invalid
        add_step(op_wi, 32'h0080_0005, 0, 32'h0000_CCDC, 32'h0000_CCDC, 3, 0);
        add_step(op_fetch, 32'h05, 0, 0, 0, 0, 32'h0080_0000);
        add_step(op_load,  32'h05, 0, 0, 0, 0, 32'h0080_0000);
        add_step(op_load,  32'h05, 0, 0, 0, 0, 32'h00A0_0000);
        add_step(op_store, 32'h05, 0, 0, 0, 0, 32'h00A0_0000);
        add_step(op_idle,  32'h05, 0, 0, 0, 0, 32'h00A0_0000);
        add_step(op_idle,  32'h05, 0, 0, 0, 0, 32'h0080_0000);
        // 64 KB page pair through Random
        add_step(op_wr, 32'h0100_0005, 32'h0001_E000, 32'h0001_001E, 32'h0001_401E, 5, 0);
        add_step(op_load,  32'h05, 0, 0, 0, 0, 32'h0101_4000);
        add_step(op_fetch, 32'h05, 0, 0, 0, 0, 32'h0100_A000);
        add_step(op_load,  32'h05, 0, 0, 0, 0, 32'h0102_0000);
        add_step(op_read,  0, 0, 0, 0, 5, 0);
        add_step(op_read,  0, 0, 0, 0, 2, 0);
        add_step(op_read,  0, 0, 0, 0, 1, 0);
        add_step(op_probe, 32'h0040_0005, 0, 0, 0, 0, 0);
        add_step(op_probe, 32'h0060_0044, 0, 0, 0, 0, 0);
        add_step(op_probe, 32'h0101_8005, 0, 0, 0, 0, 0);
        add_step(op_probe, 32'h00A0_0005, 0, 0, 0, 0, 0);
    endtask

    initial
    begin
        int limit;
        wait (table_ready);
        limit = (steps.size() * 10 + 5) * period;
        #(limit);
        $display("timeout: the steps did not finish within %0d ns", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        rst = 1'b1;
        {inst_en, mem_read, mem_write, tlbp, tlbr, tlbwi, tlbwr} = '0;
        inst_vaddr = '0;
        data_vaddr = '0;
        entryhi_in = '0;
        pagemask_in = '0;
        entrylo0_in = '0;
        entrylo1_in = '0;
        index_in = '0;
        random_in = '0;
        for (int e = 0; e < n_entries; e++)
        begin
            ref_hi[e] = '0;
            ref_mask[e] = '0;
            ref_lo0[e] = '0;
            ref_lo1[e] = '0;
            ref_g[e] = 1'b0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < steps.size(); i++)
            apply_step(i, steps[i]);
        $display("steps %0d, checks %0d, errors %0d", steps.size(), checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- logic/mmu_top.sv
`timescale 1ns/1ps

module mmu_top #(
    parameter int n_entries = mmu_pkg::entries_default,
    parameter int index_w   = $clog2(n_entries)
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [31:0]                 inst_vaddr,
    input  logic [31:0]                 data_vaddr,
    input  logic                        inst_en,
    input  logic                        mem_read,
    input  logic                        mem_write,
    output logic [mmu_pkg::frame_w-1:0] inst_pfn,
    output logic [mmu_pkg::frame_w-1:0] data_pfn,
    output logic                        no_cache_i,
    output logic                        no_cache_d,
    output logic                        inst_tlb_refill,
    output logic                        inst_tlb_invalid,
    output logic                        data_tlb_refill,
    output logic                        data_tlb_invalid,
    output logic                        data_tlb_modify,
    input  logic                        tlbp,
    input  logic                        tlbr,
    input  logic                        tlbwi,
    input  logic                        tlbwr,
    input  logic [31:0]                 entryhi_in,
    input  logic [31:0]                 pagemask_in,
    input  logic [31:0]                 entrylo0_in,
    input  logic [31:0]                 entrylo1_in,
    input  logic [31:0]                 index_in,
    input  logic [31:0]                 random_in,
    output logic [31:0]                 entryhi_out,
    output logic [31:0]                 pagemask_out,
    output logic [31:0]                 entrylo0_out,
    output logic [31:0]                 entrylo1_out,
    output logic [31:0]                 index_out
);
    import mmu_pkg::*;

    logic [n_entries*vpn2_w-1:0] entry_vpn2;
    logic [n_entries*vpn2_w-1:0] entry_mask;
    logic [n_entries*asid_w-1:0] entry_asid;
    logic [n_entries-1:0]        entry_g;

    logic               i_hit;
    logic               d_hit;
    logic               p_hit;
    logic [index_w-1:0] i_index;
    logic [index_w-1:0] d_index;
    logic [index_w-1:0] p_index;
    logic [index_w-1:0] m_index;
    logic [index_w-1:0] w_index;
    logic               we;

    logic [31:0] i_lo0;
    logic [31:0] i_lo1;
    logic [31:0] d_lo0;
    logic [31:0] d_lo1;
    logic [31:0] m_hi;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;

    tlb_array #(
        .n_entries (n_entries),
        .index_w   (index_w)
    ) u_array (
        .clk        (clk),
        .rst        (rst),
        .we         (we),
        .w_index    (w_index),
        .w_entryhi  (entryhi_in),
        .w_pagemask (pagemask_in),
        .w_entrylo0 (entrylo0_in),
        .w_entrylo1 (entrylo1_in),
        .entry_vpn2 (entry_vpn2),
        .entry_mask (entry_mask),
        .entry_asid (entry_asid),
        .entry_g    (entry_g),
        .i_index    (i_index),
        .d_index    (d_index),
        .m_index    (m_index),
        .i_lo0      (i_lo0),
        .i_lo1      (i_lo1),
        .d_lo0      (d_lo0),
        .d_lo1      (d_lo1),
        .m_hi       (m_hi),
        .m_mask     (pagemask_out),
        .m_lo0      (m_lo0),
        .m_lo1      (m_lo1)
    );

    // all three lookups use the current ASID from EntryHi
    tlb_match #(
        .n_entries (n_entries),
        .index_w   (index_w)
    ) match_i (
        .lookup     (inst_vaddr),
        .asid       (entryhi_in[asid_w-1:0]),
        .entry_vpn2 (entry_vpn2),
        .entry_mask (entry_mask),
        .entry_asid (entry_asid),
        .entry_g    (entry_g),
        .hit        (i_hit),
        .hit_index  (i_index)
    );

    tlb_match #(
        .n_entries (n_entries),
        .index_w   (index_w)
    ) match_d (
        .lookup     (data_vaddr),
        .asid       (entryhi_in[asid_w-1:0]),
        .entry_vpn2 (entry_vpn2),
        .entry_mask (entry_mask),
        .entry_asid (entry_asid),
        .entry_g    (entry_g),
        .hit        (d_hit),
        .hit_index  (d_index)
    );

    tlb_match #(
        .n_entries (n_entries),
        .index_w   (index_w)
    ) match_p (
        .lookup     (entryhi_in),
        .asid       (entryhi_in[asid_w-1:0]),
        .entry_vpn2 (entry_vpn2),
        .entry_mask (entry_mask),
        .entry_asid (entry_asid),
        .entry_g    (entry_g),
        .hit        (p_hit),
        .hit_index  (p_index)
    );

    // fetch side has no store and no modify exception
    addr_xlate #(
        .data_side (1'b0)
    ) xlate_i (
        .vaddr       (inst_vaddr),
        .access      (inst_en),
        .store       (),
        .hit         (i_hit),
        .lo0         (i_lo0),
        .lo1         (i_lo1),
        .pfn         (inst_pfn),
        .uncached    (no_cache_i),
        .tlb_refill  (inst_tlb_refill),
        .tlb_invalid (inst_tlb_invalid),
        .tlb_modify  ()
    );

    addr_xlate #(
        .data_side (1'b1)
    ) xlate_d (
        .vaddr       (data_vaddr),
        .access      (mem_read),
        .store       (mem_write),
        .hit         (d_hit),
        .lo0         (d_lo0),
        .lo1         (d_lo1),
        .pfn         (data_pfn),
        .uncached    (no_cache_d),
        .tlb_refill  (data_tlb_refill),
        .tlb_invalid (data_tlb_invalid),
        .tlb_modify  (data_tlb_modify)
    );

    tlb_maint #(
        .index_w (index_w)
    ) u_maint (
        .tlbp         (tlbp),
        .tlbr         (tlbr),
        .tlbwi        (tlbwi),
        .tlbwr        (tlbwr),
        .index_in     (index_in),
        .random_in    (random_in),
        .probe_hit    (p_hit),
        .probe_index  (p_index),
        .m_hi         (m_hi),
        .m_lo0        (m_lo0),
        .m_lo1        (m_lo1),
        .we           (we),
        .w_index      (w_index),
        .m_index      (m_index),
        .index_out    (index_out),
        .entryhi_out  (entryhi_out),
        .entrylo0_out (entrylo0_out),
        .entrylo1_out (entrylo1_out)
    );

endmodule

//--- logic/tlb_maint.sv
`timescale 1ns/1ps

module tlb_maint #(
    parameter int index_w = 3
) (
    input  logic               tlbp,
    input  logic               tlbr,
    input  logic               tlbwi,
    input  logic               tlbwr,
    input  logic [31:0]        index_in,
    input  logic [31:0]        random_in,
    input  logic               probe_hit,
    input  logic [index_w-1:0] probe_index,
    input  logic [31:0]        m_hi,
    input  logic [31:0]        m_lo0,
    input  logic [31:0]        m_lo1,
    output logic               we,
    output logic [index_w-1:0] w_index,
    output logic [index_w-1:0] m_index,
    output logic [31:0]        index_out,
    output logic [31:0]        entryhi_out,
    output logic [31:0]        entrylo0_out,
    output logic [31:0]        entrylo1_out
);
    import mmu_pkg::*;

    logic g_stored;

    // TLBWI uses Index, TLBWR uses Random
    assign we      = tlbwi | tlbwr;
    assign w_index = tlbwi ? index_in[index_w-1:0] : random_in[index_w-1:0];

    // probe reads back the matching entry
    assign m_index = tlbp ? probe_index : index_in[index_w-1:0];

    // probe result with the P bit set on a miss
    assign index_out = probe_hit ? {{(32-index_w){1'b0}}, probe_index} : probe_miss;

    assign g_stored = m_hi[g_pos];

    // G of each EntryLo comes back from the combined global bit
    assign entryhi_out  = m_hi;
    assign entrylo0_out = {m_lo0[31:g0_pos+1], g_stored};
    assign entrylo1_out = {m_lo1[31:g0_pos+1], g_stored};

endmodule

//--- logic/addr_xlate.sv
`timescale 1ns/1ps

module addr_xlate #(
    parameter bit data_side = 1'b0
) (
    input  logic [31:0]                 vaddr,
    input  logic                        access,
    input  logic                        store,
    input  logic                        hit,
    input  logic [31:0]                 lo0,
    input  logic [31:0]                 lo1,
    output logic [mmu_pkg::frame_w-1:0] pfn,
    output logic                        uncached,
    output logic                        tlb_refill,
    output logic                        tlb_invalid,
    output logic                        tlb_modify
);
    import mmu_pkg::*;

    logic        unmapped;
    logic        kseg1;
    logic        window;
    logic        any_access;
    logic        wr_access;
    logic [31:0] lo_sel;
    logic        valid;
    logic        dirty;

    // kseg0 and kseg1 bypass the TLB
    assign unmapped = vaddr[31:30] == 2'b10;
    assign kseg1    = vaddr[31:29] == 3'b101;

    // monitor user space 0x8010_0000..0x803F_FFFF, kept out of the caches
    assign window = data_side && vaddr[31] && !(|vaddr[30:22]) && (|vaddr[21:20]);

    // data side sees load or store, fetch side only the enable
    assign any_access = data_side ? (access | store) : access;
    assign wr_access  = data_side ? store : 1'b0;

    // bit 12 picks the odd page of the pair
    assign lo_sel = vaddr[offset_w] ? lo1 : lo0;
    assign valid  = lo_sel[v_pos];
    assign dirty  = lo_sel[d_pos];

    always_comb
    begin
        if (unmapped)
        begin
            pfn      = {3'b000, vaddr[offset_w+frame_w-4:offset_w]};
            uncached = kseg1 | window;
        end
        else
        begin
            pfn      = lo_sel[pfn_hi:pfn_lo];
            uncached = lo_sel[c_hi:c_lo] == uncached_attr;
        end
    end

    // no TLB exceptions outside the mapped segments
    assign tlb_refill  = !unmapped && any_access && !hit;
    assign tlb_invalid = !unmapped && any_access && hit && !valid;
    assign tlb_modify  = !unmapped && wr_access && hit && valid && !dirty;

endmodule

//--- logic/tlb_match.sv
`timescale 1ns/1ps

module tlb_match #(
    parameter int n_entries = 8,
    parameter int index_w   = 3
) (
    input  logic [31:0]                           lookup,
    input  logic [mmu_pkg::asid_w-1:0]            asid,
    input  logic [n_entries*mmu_pkg::vpn2_w-1:0] entry_vpn2,
    input  logic [n_entries*mmu_pkg::vpn2_w-1:0] entry_mask,
    input  logic [n_entries*mmu_pkg::asid_w-1:0] entry_asid,
    input  logic [n_entries-1:0]                  entry_g,
    output logic                                  hit,
    output logic [index_w-1:0]                    hit_index
);
    import mmu_pkg::*;

    logic [vpn2_w-1:0]    vpn2;
    logic [n_entries-1:0] vpn_eq;
    logic [n_entries-1:0] asid_ok;
    logic [n_entries-1:0] hit_mask;

    assign vpn2 = lookup[vpn2_hi:vpn2_lo];

    for (genvar e = 0; e < n_entries; e++)
    begin : g_cmp
        // masked VPN2 bits never take part in the compare
        assign vpn_eq[e] = ((vpn2 ^ entry_vpn2[e*vpn2_w +: vpn2_w])
                           & ~entry_mask[e*vpn2_w +: vpn2_w]) == '0;
        assign asid_ok[e] = entry_g[e] || (entry_asid[e*asid_w +: asid_w] == asid);
        assign hit_mask[e] = vpn_eq[e] & asid_ok[e];
    end

    assign hit = |hit_mask;

    // OR encoder, several hits merge their indices
    always_comb
    begin
        hit_index = '0;
        for (int e = 0; e < n_entries; e++)
        begin
            if (hit_mask[e])
                hit_index = hit_index | index_w'(e);
        end
    end

endmodule

//--- logic/tlb_array.sv
`timescale 1ns/1ps

module tlb_array #(
    parameter int n_entries = 8,
    parameter int index_w   = 3
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  we,
    input  logic [index_w-1:0]                    w_index,
    input  logic [31:0]                           w_entryhi,
    input  logic [31:0]                           w_pagemask,
    input  logic [31:0]                           w_entrylo0,
    input  logic [31:0]                           w_entrylo1,
    output logic [n_entries*mmu_pkg::vpn2_w-1:0] entry_vpn2,
    output logic [n_entries*mmu_pkg::vpn2_w-1:0] entry_mask,
    output logic [n_entries*mmu_pkg::asid_w-1:0] entry_asid,
    output logic [n_entries-1:0]                  entry_g,
    input  logic [index_w-1:0]                    i_index,
    input  logic [index_w-1:0]                    d_index,
    input  logic [index_w-1:0]                    m_index,
    output logic [31:0]                           i_lo0,
    output logic [31:0]                           i_lo1,
    output logic [31:0]                           d_lo0,
    output logic [31:0]                           d_lo1,
    output logic [31:0]                           m_hi,
    output logic [31:0]                           m_mask,
    output logic [31:0]                           m_lo0,
    output logic [31:0]                           m_lo1
);
    import mmu_pkg::*;

    logic [31:0] hi_q   [n_entries];
    logic [31:0] mask_q [n_entries];
    logic [31:0] lo0_q  [n_entries];
    logic [31:0] lo1_q  [n_entries];

    logic [31:0] hi_d;

    // only PFN, C, D and V survive a write
    function automatic logic [31:0] keep_lo(input logic [31:0] lo);
        logic [31:0] r;
        r = '0;
        r[pfn_hi:pfn_lo] = lo[pfn_hi:pfn_lo];
        r[c_hi:c_lo] = lo[c_hi:c_lo];
        r[d_pos] = lo[d_pos];
        r[v_pos] = lo[v_pos];
        return r;
    endfunction

    // entry is global only when both halves say so
    always_comb
    begin
        hi_d = '0;
        hi_d[vpn2_hi:vpn2_lo] = w_entryhi[vpn2_hi:vpn2_lo];
        hi_d[g_pos] = w_entrylo0[g0_pos] & w_entrylo1[g0_pos];
        hi_d[asid_w-1:0] = w_entryhi[asid_w-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int e = 0; e < n_entries; e++)
            begin
                hi_q[e]   <= '0;
                mask_q[e] <= '0;
                lo0_q[e]  <= '0;
                lo1_q[e]  <= '0;
            end
        end
        else if (we)
        begin
            hi_q[w_index]   <= hi_d;
            mask_q[w_index] <= w_pagemask;
            lo0_q[w_index]  <= keep_lo(w_entrylo0);
            lo1_q[w_index]  <= keep_lo(w_entrylo1);
        end
    end

    // compare fields for the matchers, entry e at slice e
    for (genvar e = 0; e < n_entries; e++)
    begin : g_flat
        assign entry_vpn2[e*vpn2_w +: vpn2_w] = hi_q[e][vpn2_hi:vpn2_lo];
        assign entry_mask[e*vpn2_w +: vpn2_w] = mask_q[e][vpn2_hi:vpn2_lo];
        assign entry_asid[e*asid_w +: asid_w] = hi_q[e][asid_w-1:0];
        assign entry_g[e] = hi_q[e][g_pos];
    end

    // asynchronous read ports
    assign i_lo0  = lo0_q[i_index];
    assign i_lo1  = lo1_q[i_index];
    assign d_lo0  = lo0_q[d_index];
    assign d_lo1  = lo1_q[d_index];
    assign m_hi   = hi_q[m_index];
    assign m_mask = mask_q[m_index];
    assign m_lo0  = lo0_q[m_index];
    assign m_lo1  = lo1_q[m_index];

endmodule

//--- logic/mmu_pkg.sv
package mmu_pkg;

    // TLB size used when the top level is not overridden
    localparam int entries_default = 8;

    // VPN2 field, same position in EntryHi and in a virtual address
    localparam int vpn2_hi = 31;
    localparam int vpn2_lo = 13;
    localparam int vpn2_w  = vpn2_hi - vpn2_lo + 1;

    // address space identifier in EntryHi[7:0]
    localparam int asid_w = 8;

    // global bit as kept inside a stored EntryHi
    // the architectural EntryHi has nothing at this position
    localparam int g_pos = 12;

    // EntryLo fields
    localparam int pfn_hi = 25;
    localparam int pfn_lo = 6;
    localparam int c_hi   = 5;
    localparam int c_lo   = 3;
    localparam int d_pos  = 2;
    localparam int v_pos  = 1;
    localparam int g0_pos = 0;

    // physical page frame and page offset
    localparam int frame_w = 20;
    // offset width doubles as the even/odd page select bit
    localparam int offset_w = 12;

    // C field encoding for uncached access
    localparam logic [2:0] uncached_attr = 3'b010;

    // probe result when nothing matches, P bit set
    localparam logic [31:0] probe_miss = 32'h8000_0000;

endpackage
